//--- list.f
+incdir+.
sram_pkg.sv
sram_ram_dp_be.sv
sram_boot_ctrl.sv
sram.sv
sram_top.sv
tb_sram.sv

//--- sram.sv
`default_nettype none

`include "sram_macros.svh"

// main memory with instruction and data ports on the native bus
module sram (
   input  wire logic                clk_i,
   input  wire logic                arst_n_i,

   input  wire sram_pkg::sram_req_t ibus_req_i,  // writable only while booting
   input  wire sram_pkg::sram_req_t dbus_req_i,
   output sram_pkg::sram_rsp_t      ibus_rsp_o,
   output sram_pkg::sram_rsp_t      dbus_rsp_o
);

   logic [`SRAM_DATA_W-1:0] i_rdata;
   logic [`SRAM_DATA_W-1:0] d_rdata;
   logic                    i_rd;
   logic                    d_rd;
   logic                    i_rvalid_q;
   logic                    d_rvalid_q;

   // read = access with an empty strobe
   assign i_rd = ibus_req_i.avalid && !(|ibus_req_i.wstrb);
   assign d_rd = dbus_req_i.avalid && !(|dbus_req_i.wstrb);

   // data on port a, instruction on port b
   sram_ram_dp_be i_ram (
      .clk_i   (clk_i),

      .a_en_i  (dbus_req_i.avalid),
      .a_addr_i(dbus_req_i.addr),
      .a_we_i  (dbus_req_i.wstrb),
      .a_d_i   (dbus_req_i.wdata),
      .a_d_o   (d_rdata),

      .b_en_i  (ibus_req_i.avalid),
      .b_addr_i(ibus_req_i.addr),
      .b_we_i  (ibus_req_i.wstrb),
      .b_d_i   (ibus_req_i.wdata),
      .b_d_o   (i_rdata)
   );

   // rvalid lines up with the registered RAM output
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
      end else begin
         i_rvalid_q <= i_rd;
         d_rvalid_q <= d_rd;
      end
   end

   always_comb begin
      ibus_rsp_o.rdata  = i_rdata;
      ibus_rsp_o.rvalid = i_rvalid_q;
      ibus_rsp_o.ready  = 1'b1;  // continuous requests, never stalls

      dbus_rsp_o.rdata  = d_rdata;
      dbus_rsp_o.rvalid = d_rvalid_q;
      dbus_rsp_o.ready  = 1'b1;
   end

   a_i_no_rvalid_after_wr : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (ibus_req_i.avalid && (|ibus_req_i.wstrb)) |=> !ibus_rsp_o.rvalid
   ) else $error("instruction rvalid after a write");

   a_d_no_rvalid_after_wr : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (dbus_req_i.avalid && (|dbus_req_i.wstrb)) |=> !dbus_rsp_o.rvalid
   ) else $error("data rvalid after a write");

endmodule

`default_nettype wire

//--- sram_boot_ctrl.sv
`default_nettype none

// boot level register in front of the instruction port
// after boot the instruction port becomes read only
module sram_boot_ctrl (
   input  wire logic                clk_i,
   input  wire logic                arst_n_i,
   input  wire sram_pkg::sram_cfg_t cfg_i,
   input  wire sram_pkg::sram_req_t ireq_i,   // raw from fetch/loader
   output sram_pkg::sram_req_t      ireq_o,   // filtered towards memory
   output logic                     boot_o,
   output logic                     ibus_err_o
);

   logic boot_q;
   logic err_q;
   logic illegal_wr;

   // write attempt while not booting
   assign illegal_wr = ireq_i.avalid && (|ireq_i.wstrb) && !boot_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         boot_q <= 1'b1;  // come up booting
         err_q  <= 1'b0;
      end else if (cfg_i.we) begin
         boot_q <= cfg_i.boot;
         err_q  <= 1'b0;  // config write clears the sticky flag
      end else if (illegal_wr) begin
         err_q  <= 1'b1;
      end
   end

   // a dropped request neither writes nor returns rvalid
   always_comb begin
      ireq_o        = ireq_i;
      ireq_o.avalid = ireq_i.avalid && !illegal_wr;
   end

   assign boot_o     = boot_q;
   assign ibus_err_o = err_q;

   a_no_wr_after_boot : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      !boot_o |-> !(ireq_o.avalid && (|ireq_o.wstrb))
   ) else $error("instruction write forwarded outside boot");

endmodule

`default_nettype wire

//--- sram_macros.svh
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// word and byte-address geometry of the main memory
`define SRAM_DATA_W 32
`define SRAM_ADDR_W 12  // 4 KiB

// word address drops the two byte-offset bits
`define SRAM_WORD_ADDR_W (`SRAM_ADDR_W - 2)

// one write strobe per byte lane
`define SRAM_STRB_W (`SRAM_DATA_W / 8)

`endif

//--- sram_pkg.sv
`default_nettype none

`include "sram_macros.svh"

package sram_pkg;

   // native bus request, one per port
   typedef struct packed {
      logic                         avalid;  // access strobe
      logic [`SRAM_WORD_ADDR_W-1:0] addr;    // word address
      logic [`SRAM_DATA_W-1:0]      wdata;
      logic [`SRAM_STRB_W-1:0]      wstrb;   // all zero means read
   } sram_req_t;

   // native bus response
   typedef struct packed {
      logic [`SRAM_DATA_W-1:0] rdata;
      logic                    rvalid;  // one-cycle pulse after a read
      logic                    ready;   // tied high by the memory
   } sram_rsp_t;

   // boot configuration write
   typedef struct packed {
      logic we;    // write strobe
      logic boot;  // new boot level, 1 while loading
   } sram_cfg_t;

endpackage

`default_nettype wire

//--- sram_ram_dp_be.sv
`default_nettype none

`include "sram_macros.svh"

// true dual-port RAM with per-byte write enables
// each port reads the addressed word into a register when enabled
module sram_ram_dp_be (
   input  wire logic                         clk_i,

   // port a
   input  wire logic                         a_en_i,
   input  wire logic [`SRAM_WORD_ADDR_W-1:0] a_addr_i,
   input  wire logic [`SRAM_STRB_W-1:0]      a_we_i,
   input  wire logic [`SRAM_DATA_W-1:0]      a_d_i,
   output logic      [`SRAM_DATA_W-1:0]      a_d_o,

   // port b
   input  wire logic                         b_en_i,
   input  wire logic [`SRAM_WORD_ADDR_W-1:0] b_addr_i,
   input  wire logic [`SRAM_STRB_W-1:0]      b_we_i,
   input  wire logic [`SRAM_DATA_W-1:0]      b_d_i,
   output logic      [`SRAM_DATA_W-1:0]      b_d_o
);

   localparam int unsigned DEPTH = 2 ** `SRAM_WORD_ADDR_W;

   logic [`SRAM_DATA_W-1:0] mem [DEPTH];  // content undefined until written

   // port a, read sees the old word on a write
   always @(posedge clk_i) begin
      if (a_en_i) begin
         for (int i = 0; i < `SRAM_STRB_W; i++) begin
            if (a_we_i[i]) mem[a_addr_i][i*8 +: 8] <= a_d_i[i*8 +: 8];
         end
         a_d_o <= mem[a_addr_i];
      end
   end

   // port b
   always @(posedge clk_i) begin
      if (b_en_i) begin
         for (int i = 0; i < `SRAM_STRB_W; i++) begin
            if (b_we_i[i]) mem[b_addr_i][i*8 +: 8] <= b_d_i[i*8 +: 8];
         end
         b_d_o <= mem[b_addr_i];
      end
   end

   // same-word writes from both ports in one cycle have no defined winner
   a_no_dual_write : assert property (
      @(posedge clk_i)
      !(a_en_i && b_en_i && (|a_we_i) && (|b_we_i) && (a_addr_i == b_addr_i))
   ) else $error("both ports write word %0h in the same cycle", a_addr_i);

endmodule

`default_nettype wire

//--- sram_top.sv
`default_nettype none

// memory subsystem, boot filter ahead of the instruction port
module sram_top (
   input  wire logic                clk_i,
   input  wire logic                arst_n_i,

   // boot configuration
   input  wire sram_pkg::sram_cfg_t cfg_i,

   // buses
   input  wire sram_pkg::sram_req_t ibus_req_i,
   input  wire sram_pkg::sram_req_t dbus_req_i,
   output sram_pkg::sram_rsp_t      ibus_rsp_o,
   output sram_pkg::sram_rsp_t      dbus_rsp_o,

   // status
   output logic                     boot_o,
   output logic                     ibus_err_o
);

   sram_pkg::sram_req_t ibus_req_f;  // after boot filtering

   sram_boot_ctrl i_boot_ctrl (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .cfg_i     (cfg_i),
      .ireq_i    (ibus_req_i),
      .ireq_o    (ibus_req_f),
      .boot_o    (boot_o),
      .ibus_err_o(ibus_err_o)
   );

   // data bus goes straight through
   sram i_sram (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .ibus_req_i(ibus_req_f),
      .dbus_req_i(dbus_req_i),
      .ibus_rsp_o(ibus_rsp_o),
      .dbus_rsp_o(dbus_rsp_o)
   );

endmodule

`default_nettype wire

//--- tb_sram.sv
`default_nettype none

`include "sram_macros.svh"

module tb_sram;

   localparam int TIMEOUT_CYCLES = 2000;  // far beyond the roughly 360 test cycles

   logic                clk;
   logic                arst_n;
   sram_pkg::sram_cfg_t cfg;
   sram_pkg::sram_req_t ibus_req;
   sram_pkg::sram_req_t dbus_req;
   sram_pkg::sram_rsp_t ibus_rsp;
   sram_pkg::sram_rsp_t dbus_rsp;
   logic                boot;
   logic                ibus_err;

   // reference model state
   logic [`SRAM_DATA_W-1:0] model_mem [2 ** `SRAM_WORD_ADDR_W];
   logic                    mdl_boot;  // boot level after the coming edge
   logic                    mdl_err;

   // expected responses for the request on the bus now, and one cycle later
   sram_pkg::sram_rsp_t i_exp;
   sram_pkg::sram_rsp_t d_exp;
   sram_pkg::sram_rsp_t i_pend;
   sram_pkg::sram_rsp_t d_pend;
   logic                boot_pend;
   logic                err_pend;

   integer seed = 99;
   int     cycles = 0;
   logic [`SRAM_STRB_W-1:0] strb_tab [8] = '{4'b0001, 4'b0011, 4'b1100, 4'b0110,
                                             4'b1000, 4'b0100, 4'b1010, 4'b0010};

   sram_top i_dut (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .cfg_i     (cfg),
      .ibus_req_i(ibus_req),
      .dbus_req_i(dbus_req),
      .ibus_rsp_o(ibus_rsp),
      .dbus_rsp_o(dbus_rsp),
      .boot_o    (boot),
      .ibus_err_o(ibus_err)
   );

   always #4 clk = ~clk;

   // stored word with the strobed bytes of wdata merged in
   function automatic logic [`SRAM_DATA_W-1:0] ref_read(
      input logic [`SRAM_WORD_ADDR_W-1:0] addr,
      input logic [`SRAM_DATA_W-1:0]      wdata,
      input logic [`SRAM_STRB_W-1:0]      wstrb
   );
      logic [`SRAM_DATA_W-1:0] word;
      word = model_mem[addr];
      for (int i = 0; i < `SRAM_STRB_W; i++) begin
         if (wstrb[i]) word[i*8 +: 8] = wdata[i*8 +: 8];
      end
      return word;
   endfunction

   function automatic sram_pkg::sram_req_t mk_req(
      input logic                         avalid,
      input logic [`SRAM_WORD_ADDR_W-1:0] addr,
      input logic [`SRAM_DATA_W-1:0]      wdata,
      input logic [`SRAM_STRB_W-1:0]      wstrb
   );
      sram_pkg::sram_req_t r;
      r.avalid = avalid;
      r.addr   = addr;
      r.wdata  = wdata;
      r.wstrb  = wstrb;
      return r;
   endfunction

   // fill pattern that carries every address bit
   function automatic logic [`SRAM_DATA_W-1:0] fill_word(input logic [9:0] a);
      return {a, 6'h2a, ~a, 6'h15};
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_rsp(
      input string               name,
      input sram_pkg::sram_rsp_t got,
      input sram_pkg::sram_rsp_t exp
   );
      if (got.ready !== exp.ready)
         abort_run($sformatf("Fail %s.ready got %h expected %h", name, got.ready, exp.ready));
      if (exp.rvalid === 1'b0 && got.rvalid !== 1'b0)
         abort_run($sformatf("%s raised rvalid although no read was issued", name));
      if (exp.rvalid === 1'b1 && got.rvalid !== 1'b1)
         abort_run($sformatf("%s gave no rvalid one cycle after a read", name));
      if (exp.rvalid === 1'b1 && got.rdata !== exp.rdata)
         abort_run($sformatf("Fail %s.rdata got %h expected %h", name, got.rdata, exp.rdata));
   endtask

   task automatic check_status(
      input logic boot_got,
      input logic err_got,
      input logic boot_exp,
      input logic err_exp
   );
      if (boot_got !== boot_exp)
         abort_run($sformatf("Fail boot_o got %h expected %h", boot_got, boot_exp));
      if (err_got !== err_exp)
         abort_run($sformatf("Fail ibus_err_o got %h expected %h", err_got, err_exp));
   endtask

   // drives one bus cycle and updates the model to match
   task automatic drive_cycle(
      input sram_pkg::sram_req_t ireq,
      input sram_pkg::sram_req_t dreq,
      input sram_pkg::sram_cfg_t c
   );
      logic illegal;
      @(posedge clk);
      #1;
      illegal = ireq.avalid && (|ireq.wstrb) && !mdl_boot;
      // reads return the old word so expect them before the writes
      i_exp.ready  = 1'b1;
      i_exp.rvalid = ireq.avalid && !(|ireq.wstrb);
      i_exp.rdata  = ref_read(ireq.addr, '0, '0);
      d_exp.ready  = 1'b1;
      d_exp.rvalid = dreq.avalid && !(|dreq.wstrb);
      d_exp.rdata  = ref_read(dreq.addr, '0, '0);
      if (dreq.avalid && (|dreq.wstrb))
         model_mem[dreq.addr] = ref_read(dreq.addr, dreq.wdata, dreq.wstrb);
      if (ireq.avalid && (|ireq.wstrb) && !illegal)
         model_mem[ireq.addr] = ref_read(ireq.addr, ireq.wdata, ireq.wstrb);
      if (c.we) begin
         mdl_boot = c.boot;
         mdl_err  = 1'b0;
      end else if (illegal) begin
         mdl_err = 1'b1;  // sticky
      end
      ibus_req = ireq;
      dbus_req = dreq;
      cfg      = c;
   endtask

   // checks last cycle's expectations at the falling edge
   always begin
      @(posedge clk);
      i_pend    = i_exp;
      d_pend    = d_exp;
      boot_pend = mdl_boot;
      err_pend  = mdl_err;
      @(negedge clk);
      if (arst_n) begin
         check_rsp("ibus_rsp_o", ibus_rsp, i_pend);
         check_rsp("dbus_rsp_o", dbus_rsp, d_pend);
         check_status(boot, ibus_err, boot_pend, err_pend);
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
         abort_run($sformatf("timeout, tests not finished after %0d cycles", cycles));
   end

   initial begin
      sram_pkg::sram_req_t idle;
      sram_pkg::sram_cfg_t no_cfg;
      logic [31:0]         r;
      logic [31:0]         wd;
      idle     = mk_req(1'b0, '0, '0, '0);
      no_cfg   = '0;
      clk      = 1'b0;
      arst_n   = 1'b0;
      cfg      = '0;
      ibus_req = '0;
      dbus_req = '0;
      mdl_boot = 1'b1;
      mdl_err  = 1'b0;
      i_exp    = '{rdata: '0, rvalid: 1'b0, ready: 1'b1};
      d_exp    = '{rdata: '0, rvalid: 1'b0, ready: 1'b1};
      repeat (4) @(posedge clk);
      #1 arst_n = 1'b1;
      drive_cycle(idle, idle, no_cfg);  // reset values

      // loader fills the low words and patches some with partial strobes
      for (int a = 0; a < 64; a++) drive_cycle(mk_req(1'b1, a, fill_word(a), 4'hf), idle, no_cfg);
      for (int k = 0; k < 8; k++) begin
         wd = $random(seed);
         drive_cycle(mk_req(1'b1, k * 5, wd, strb_tab[k]), idle, no_cfg);
      end
      for (int a = 0; a < 64; a++) begin
         drive_cycle(mk_req(1'b1, a, '0, '0), mk_req(1'b1, 63 - a, '0, '0), no_cfg);
      end

      // random data traffic with instruction fetches alongside
      for (int n = 0; n < 200; n++) begin
         r  = $random(seed);
         wd = $random(seed);
         drive_cycle(mk_req(r[20], r[17:12], '0, '0),
                     mk_req(1'b1, r[5:0], wd, r[31] ? r[11:8] : 4'h0), no_cfg);
      end

      // same-word read and write on opposite ports return the old word first
      drive_cycle(mk_req(1'b1, 10, '0, '0), mk_req(1'b1, 10, 32'hcafe_0010, 4'hf), no_cfg);
      drive_cycle(mk_req(1'b1, 10, '0, '0), idle, no_cfg);
      drive_cycle(mk_req(1'b1, 11, 32'hbeef_0011, 4'hf), mk_req(1'b1, 11, '0, '0), no_cfg);
      drive_cycle(idle, mk_req(1'b1, 11, '0, '0), no_cfg);

      // instruction writes are dropped once boot ends
      drive_cycle(idle, idle, '{we: 1'b1, boot: 1'b0});
      drive_cycle(mk_req(1'b1, 12, 32'hdead_0012, 4'hf), idle, no_cfg);
      drive_cycle(mk_req(1'b1, 12, '0, '0), mk_req(1'b1, 12, '0, '0), no_cfg);
      drive_cycle(idle, idle, no_cfg);

      // returning to boot allows instruction writes again
      drive_cycle(idle, idle, '{we: 1'b1, boot: 1'b1});
      drive_cycle(mk_req(1'b1, 12, 32'h600d_0012, 4'hf), idle, no_cfg);
      drive_cycle(mk_req(1'b1, 12, '0, '0), mk_req(1'b1, 12, '0, '0), no_cfg);
      repeat (2) drive_cycle(idle, idle, no_cfg);

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire
